//--- ninjin_axi_pkg.sv
package ninjin_axi_pkg;

  // ==============================
  // AXI4-Lite widths
  // ==============================

  localparam int axi_dwidth = 32;
  localparam int axi_awidth = 7;
  // byte offset inside one word
  localparam int axi_lsb    = 2;

  localparam logic [1:0] axi_resp_okay = 2'b00;

  // ==============================
  // channel bundles
  // ==============================

  // master side of all five channels
  typedef struct packed {
    logic [axi_awidth-1:0]   awaddr;
    logic [2:0]              awprot;
    logic                    awvalid;
    logic [axi_dwidth-1:0]   wdata;
    logic [axi_dwidth/8-1:0] wstrb;
    logic                    wvalid;
    logic                    bready;
    logic [axi_awidth-1:0]   araddr;
    logic [2:0]              arprot;
    logic                    arvalid;
    logic                    rready;
  } ninjin_axi_req_t;

  // slave side
  typedef struct packed {
    logic                  awready;
    logic                  wready;
    logic                  bvalid;
    logic [1:0]            bresp;
    logic                  arready;
    logic                  rvalid;
    logic [axi_dwidth-1:0] rdata;
    logic [1:0]            rresp;
  } ninjin_axi_rsp_t;

endpackage

//--- ninjin_core_pkg.sv
package ninjin_core_pkg;

  // ==============================
  // register map
  // ==============================

  localparam int port_num = 8;
  localparam int port_aw  = $clog2(port_num);

  // processor to logic
  localparam int reg_ctrl   = 0;
  localparam int reg_weight = 1;
  localparam int reg_input  = 2;
  localparam int reg_bias   = 3;

  // logic to processor
  localparam int reg_status = 4;
  localparam int reg_result = 5;
  localparam int reg_lane0  = 6;
  localparam int reg_lane1  = 7;

  // ctrl bits
  localparam int ctrl_start = 0;
  localparam int ctrl_relu  = 1;

  // ==============================
  // data types
  // ==============================

  typedef logic [31:0] port_word_t;

  // two byte pairs for one lane
  typedef struct packed {
    logic signed [7:0] w0;
    logic signed [7:0] w1;
    logic signed [7:0] x0;
    logic signed [7:0] x1;
    logic              valid;
  } lane_operand_t;

  typedef struct packed {
    logic signed [31:0] sum;
    logic               valid;
  } lane_sum_t;

  // per job settings taken at start
  typedef struct packed {
    logic signed [31:0] bias;
    logic               relu_en;
  } job_cfg_t;

endpackage

//--- ninjin_s_axi_lite.sv
`timescale 1ns/1ps

module ninjin_s_axi_lite
  ( input  logic                            clk
  , input  logic                            xrst
  , input  ninjin_axi_pkg::ninjin_axi_req_t s_axi_req
  , output ninjin_axi_pkg::ninjin_axi_rsp_t s_axi_rsp
  , input  ninjin_core_pkg::port_word_t
      out_port [ninjin_core_pkg::port_num-1:ninjin_core_pkg::port_num/2]
  , output ninjin_core_pkg::port_word_t
      in_port [ninjin_core_pkg::port_num/2-1:0]
  );

  import ninjin_axi_pkg::*;
  import ninjin_core_pkg::*;

  logic                          r_awready;
  logic [axi_awidth-1:0]         r_awaddr;
  logic                          r_wready;
  logic                          r_bvalid;
  logic                          r_arready;
  logic [axi_awidth-1:0]         r_araddr;
  logic                          r_rvalid;
  logic [axi_dwidth-1:0]         r_rdata;
  port_word_t                    r_port [port_num];

  logic                          wr_start;
  logic                          rd_start;
  logic                          port_we;
  logic                          port_re;
  logic [axi_awidth-axi_lsb-1:0] wr_idx;
  logic [axi_awidth-axi_lsb-1:0] rd_idx;
  port_word_t                    rd_word;

  // no new request while a response still waits
  assign wr_start = !r_awready && !r_bvalid && s_axi_req.awvalid && s_axi_req.wvalid;
  assign rd_start = !r_arready && !r_rvalid && s_axi_req.arvalid;

  assign port_we = r_awready && s_axi_req.awvalid && r_wready && s_axi_req.wvalid;
  assign port_re = r_arready && s_axi_req.arvalid && !r_rvalid;

  assign wr_idx = r_awaddr[axi_awidth-1:axi_lsb];
  assign rd_idx = r_araddr[axi_awidth-1:axi_lsb];

  // ==============================
  // write address
  // ==============================

  always_ff @(posedge clk) begin
    if (!xrst) begin
      r_awready <= 1'b0;
      r_awaddr  <= '0;
    end else begin
      r_awready <= wr_start;
      if (wr_start) begin
        r_awaddr <= s_axi_req.awaddr;
      end
    end
  end

  // ==============================
  // write data and response
  // ==============================

  always_ff @(posedge clk) begin
    if (!xrst) begin
      r_wready <= 1'b0;
    end else begin
      r_wready <= wr_start;
    end
  end

  // held until bready
  always_ff @(posedge clk) begin
    if (!xrst) begin
      r_bvalid <= 1'b0;
    end else if (port_we && !r_bvalid) begin
      r_bvalid <= 1'b1;
    end else if (r_bvalid && s_axi_req.bready) begin
      r_bvalid <= 1'b0;
    end
  end

  // ==============================
  // read address and data
  // ==============================

  always_ff @(posedge clk) begin
    if (!xrst) begin
      r_arready <= 1'b0;
      r_araddr  <= '0;
    end else begin
      r_arready <= rd_start;
      if (rd_start) begin
        r_araddr <= s_axi_req.araddr;
      end
    end
  end

  // holes in the map read as zero
  always_comb begin
    if (rd_idx < port_num) begin
      rd_word = r_port[rd_idx[port_aw-1:0]];
    end else begin
      rd_word = '0;
    end
  end

  always_ff @(posedge clk) begin
    if (!xrst) begin
      r_rvalid <= 1'b0;
      r_rdata  <= '0;
    end else begin
      if (port_re) begin
        r_rvalid <= 1'b1;
        r_rdata  <= rd_word;
      end else if (r_rvalid && s_axi_req.rready) begin
        r_rvalid <= 1'b0;
      end
    end
  end

  // ==============================
  // port registers
  // ==============================

  always_ff @(posedge clk) begin
    if (!xrst) begin
      for (int i = 0; i < port_num; i++) begin
        r_port[i] <= '0;
      end
    end else if (port_we) begin
      // out of range index is dropped
      if (wr_idx < port_num) begin
        for (int b = 0; b < axi_dwidth / 8; b++) begin
          if (s_axi_req.wstrb[b]) begin
            r_port[wr_idx[port_aw-1:0]][b*8 +: 8] <= s_axi_req.wdata[b*8 +: 8];
          end
        end
      end
    end else begin
      // logic to processor half follows the core
      for (int i = port_num / 2; i < port_num; i++) begin
        r_port[i] <= out_port[i];
      end
    end
  end

  always_comb begin
    for (int i = 0; i < port_num / 2; i++) begin
      in_port[i] = r_port[i];
    end
  end

  always_comb begin
    s_axi_rsp.awready = r_awready;
    s_axi_rsp.wready  = r_wready;
    s_axi_rsp.bvalid  = r_bvalid;
    s_axi_rsp.bresp   = axi_resp_okay;
    s_axi_rsp.arready = r_arready;
    s_axi_rsp.rvalid  = r_rvalid;
    s_axi_rsp.rdata   = r_rdata;
    s_axi_rsp.rresp   = axi_resp_okay;
  end

endmodule

//--- ninjin_mac_lane.sv
`timescale 1ns/1ps

module ninjin_mac_lane
  ( input  logic                           clk
  , input  logic                           xrst
  , input  ninjin_core_pkg::lane_operand_t operand
  , output ninjin_core_pkg::lane_sum_t     sum
  );

  logic signed [15:0] prod0;
  logic signed [15:0] prod1;
  logic               prod_valid;

  // ==============================
  // stage 1 products
  // ==============================

  always_ff @(posedge clk) begin
    if (!xrst) begin
      prod_valid <= 1'b0;
    end else begin
      prod_valid <= operand.valid;
    end
  end

  // signed 8x8 fits in 16 bits
  always_ff @(posedge clk) begin
    prod0 <= operand.w0 * operand.x0;
    prod1 <= operand.w1 * operand.x1;
  end

  // ==============================
  // stage 2 lane sum
  // ==============================

  always_ff @(posedge clk) begin
    if (!xrst) begin
      sum.valid <= 1'b0;
      sum.sum   <= '0;
    end else begin
      sum.valid <= prod_valid;
      // sign extend before adding
      sum.sum   <= 32'(prod0) + 32'(prod1);
    end
  end

endmodule

//--- ninjin_combine.sv
`timescale 1ns/1ps

module ninjin_combine
  ( input  logic                        clk
  , input  logic                        xrst
  , input  ninjin_core_pkg::lane_sum_t  sum0
  , input  ninjin_core_pkg::lane_sum_t  sum1
  , input  ninjin_core_pkg::job_cfg_t   cfg
  , output ninjin_core_pkg::port_word_t result
  , output ninjin_core_pkg::port_word_t lane0
  , output ninjin_core_pkg::port_word_t lane1
  , output logic                        done
  , output logic [7:0]                  job_count
  );

  import ninjin_core_pkg::*;

  job_cfg_t           cfg_d [3];
  logic signed [31:0] total;
  logic               both_valid;

  // ==============================
  // cfg delay line
  // ==============================

  // one stage per cycle of issue and lane latency
  always_ff @(posedge clk) begin
    cfg_d[0] <= cfg;
    cfg_d[1] <= cfg_d[0];
    cfg_d[2] <= cfg_d[1];
  end

  // ==============================
  // final sum and relu
  // ==============================

  assign both_valid = sum0.valid && sum1.valid;
  assign total      = sum0.sum + sum1.sum + cfg_d[2].bias;

  always_ff @(posedge clk) begin
    if (!xrst) begin
      result    <= '0;
      lane0     <= '0;
      lane1     <= '0;
      done      <= 1'b0;
      job_count <= '0;
    end else begin
      // single cycle flag per finished job
      done <= both_valid;
      if (both_valid) begin
        if (cfg_d[2].relu_en && total < 0) begin
          result <= '0;
        end else begin
          result <= total;
        end
        lane0     <= sum0.sum;
        lane1     <= sum1.sum;
        // wraps at 256
        job_count <= job_count + 8'd1;
      end
    end
  end

endmodule

//--- ninjin_core.sv
`timescale 1ns/1ps

module ninjin_core
  ( input  logic                        clk
  , input  logic                        xrst
  , input  ninjin_core_pkg::port_word_t
      in_port [ninjin_core_pkg::port_num/2-1:0]
  , output ninjin_core_pkg::port_word_t
      out_port [ninjin_core_pkg::port_num-1:ninjin_core_pkg::port_num/2]
  );

  import ninjin_core_pkg::*;

  logic          start_q;
  logic          start_pulse;
  logic          done;
  logic          done_hold;
  logic [7:0]    job_count;
  lane_operand_t op0;
  lane_operand_t op1;
  job_cfg_t      cfg;
  lane_sum_t     sum0;
  lane_sum_t     sum1;
  port_word_t    result;
  port_word_t    lane0;
  port_word_t    lane1;

  // ==============================
  // start edge and issue
  // ==============================

  always_ff @(posedge clk) begin
    if (!xrst) begin
      start_q <= 1'b0;
    end else begin
      start_q <= in_port[reg_ctrl][ctrl_start];
    end
  end

  assign start_pulse = in_port[reg_ctrl][ctrl_start] && !start_q;

  // bytes 0,1 to lane 0 and bytes 2,3 to lane 1
  always_ff @(posedge clk) begin
    if (!xrst) begin
      op0.valid <= 1'b0;
      op1.valid <= 1'b0;
    end else begin
      op0.valid <= start_pulse;
      op1.valid <= start_pulse;
      if (start_pulse) begin
        op0.w0 <= in_port[reg_weight][7:0];
        op0.w1 <= in_port[reg_weight][15:8];
        op0.x0 <= in_port[reg_input][7:0];
        op0.x1 <= in_port[reg_input][15:8];
        op1.w0 <= in_port[reg_weight][23:16];
        op1.w1 <= in_port[reg_weight][31:24];
        op1.x0 <= in_port[reg_input][23:16];
        op1.x1 <= in_port[reg_input][31:24];
      end
    end
  end

  // enters the combiner delay line in the issue cycle
  assign cfg.bias    = in_port[reg_bias];
  assign cfg.relu_en = in_port[reg_ctrl][ctrl_relu];

  ninjin_mac_lane lane0_u (.clk(clk), .xrst(xrst), .operand(op0), .sum(sum0));
  ninjin_mac_lane lane1_u (.clk(clk), .xrst(xrst), .operand(op1), .sum(sum1));

  ninjin_combine combine0
    ( .clk       (clk)
    , .xrst      (xrst)
    , .sum0      (sum0)
    , .sum1      (sum1)
    , .cfg       (cfg)
    , .result    (result)
    , .lane0     (lane0)
    , .lane1     (lane1)
    , .done      (done)
    , .job_count (job_count)
    );

  // ==============================
  // status
  // ==============================

  // sticky done, dropped by the next start
  always_ff @(posedge clk) begin
    if (!xrst) begin
      done_hold <= 1'b0;
    end else if (start_pulse) begin
      done_hold <= 1'b0;
    end else if (done) begin
      done_hold <= 1'b1;
    end
  end

  always_comb begin
    out_port[reg_status] = {16'h0000, job_count, 7'h00, done_hold | done};
    out_port[reg_result] = result;
    out_port[reg_lane0]  = lane0;
    out_port[reg_lane1]  = lane1;
  end

endmodule

//--- ninjin_top.sv
`timescale 1ns/1ps

module ninjin_top
  ( input  logic                            clk
  , input  logic                            xrst
  , input  ninjin_axi_pkg::ninjin_axi_req_t s_axi_req
  , output ninjin_axi_pkg::ninjin_axi_rsp_t s_axi_rsp
  );

  import ninjin_core_pkg::*;

  // processor to logic
  port_word_t in_port  [port_num/2-1:0];
  // logic to processor
  port_word_t out_port [port_num-1:port_num/2];

  ninjin_s_axi_lite bank0
    ( .clk       (clk)
    , .xrst      (xrst)
    , .s_axi_req (s_axi_req)
    , .s_axi_rsp (s_axi_rsp)
    , .out_port  (out_port)
    , .in_port   (in_port)
    );

  ninjin_core core0
    ( .clk      (clk)
    , .xrst     (xrst)
    , .in_port  (in_port)
    , .out_port (out_port)
    );

endmodule

//--- ninjin_top_tb_tasks.svh
// ==============================
// AXI4-Lite master
// ==============================

// random idle cycles before a ready goes high
task automatic ready_delay();
  repeat ($urandom_range(ready_delay_max, 0) + 1) @(posedge clk);
  #1;
endtask

task automatic write_reg(input int idx, input port_word_t data, input logic [3:0] strb);
  int t;
  req.awaddr  = {idx[4:0], 2'b00};
  req.wdata   = data;
  req.wstrb   = strb;
  req.awvalid = 1'b1;
  req.wvalid  = 1'b1;
  t = 0;
  @(negedge clk);
  while (!(rsp.awready && rsp.wready)) begin
    t++;
    if (t > wait_limit) stop_on_timeout("awready and wready");
    @(negedge clk);
  end
  @(posedge clk);
  #1;
  req.awvalid = 1'b0;
  req.wvalid  = 1'b0;
  note_write(idx, data, strb);
  t = 0;
  while (!rsp.bvalid) begin
    t++;
    if (t > wait_limit) stop_on_timeout("bvalid");
    @(negedge clk);
  end
  ready_delay();
  req.bready = 1'b1;
  @(posedge clk);
  #1;
  req.bready = 1'b0;
endtask

task automatic read_reg(input int idx, output port_word_t data);
  int t;
  req.araddr  = {idx[4:0], 2'b00};
  req.arvalid = 1'b1;
  t = 0;
  @(negedge clk);
  while (!rsp.arready) begin
    t++;
    if (t > wait_limit) stop_on_timeout("arready");
    @(negedge clk);
  end
  @(posedge clk);
  #1;
  req.arvalid = 1'b0;
  t = 0;
  while (!rsp.rvalid) begin
    t++;
    if (t > wait_limit) stop_on_timeout("rvalid");
    @(negedge clk);
  end
  ready_delay();
  req.rready = 1'b1;
  // data taken mid cycle before the handshake edge
  @(negedge clk);
  data = rsp.rdata;
  @(posedge clk);
  #1;
  req.rready = 1'b0;
endtask

task automatic read_check(input int idx, input port_word_t exp);
  port_word_t got;
  read_reg(idx, got);
  if (idx < port_num) begin
    check_word(names[idx], exp, got);
  end else begin
    check_word($sformatf("index %0d", idx), exp, got);
  end
endtask

// status reads until the done bit shows
task automatic poll_done();
  port_word_t status;
  int polls;
  polls = 0;
  read_reg(reg_status, status);
  while (!status[0]) begin
    polls++;
    if (polls > wait_limit) stop_on_timeout("done in status");
    read_reg(reg_status, status);
  end
endtask

// ==============================
// reference model
// ==============================

// signed bytes first and first+1 of w times those of x
function automatic int pair_dot(port_word_t w, port_word_t x, int first);
  int w0;
  int w1;
  int x0;
  int x1;
  w0 = $signed(w[first*8 +: 8]);
  w1 = $signed(w[first*8+8 +: 8]);
  x0 = $signed(x[first*8 +: 8]);
  x1 = $signed(x[first*8+8 +: 8]);
  return w0 * x0 + w1 * x1;
endfunction

//--- ninjin_top_tb.sv
`timescale 1ns/1ps

module ninjin_top_tb;

  import ninjin_axi_pkg::*;
  import ninjin_core_pkg::*;

  localparam int wait_limit = 200;

  logic            clk;
  logic            xrst;
  ninjin_axi_req_t req;
  ninjin_axi_rsp_t rsp;

  string      names [8] = '{"ctrl", "weight", "input", "bias",
                            "status", "result", "lane0", "lane1"};
  // expected contents of the processor to logic half
  port_word_t shadow [4];
  int         jobs;
  int         pass_count;
  int         fail_count;
  int         test_fails;
  int         ready_delay_max;

  ninjin_top dut0 (.clk(clk), .xrst(xrst), .s_axi_req(req), .s_axi_rsp(rsp));

  always #2 clk = ~clk;

  // ==============================
  // response checks
  // ==============================

  assert property (@(posedge clk) disable iff (!xrst)
    rsp.bvalid && !req.bready |=> rsp.bvalid && $stable(rsp.bresp))
  else begin
    fail_count++;
    $display("bvalid or bresp changed before bready at %0t", $time);
  end

  assert property (@(posedge clk) disable iff (!xrst)
    rsp.rvalid && !req.rready |=> rsp.rvalid && $stable(rsp.rdata))
  else begin
    fail_count++;
    $display("rvalid or rdata changed before rready at %0t", $time);
  end

  assert property (@(posedge clk) disable iff (!xrst)
    (!rsp.bvalid || rsp.bresp == axi_resp_okay) && (!rsp.rvalid || rsp.rresp == axi_resp_okay))
  else begin
    fail_count++;
    $display("response code other than OKAY at %0t", $time);
  end

  function automatic void check_word(string name, port_word_t exp, port_word_t got);
    assert (got === exp) begin
      pass_count++;
    end else begin
      fail_count++;
      $display("MISMATCH at %0t: %s expected %h actual %h", $time, name, exp, got);
    end
  endfunction

  // byte merge where a 0 to 1 on start counts one job
  function automatic void note_write(int idx, port_word_t data, logic [3:0] strb);
    port_word_t old;
    if (idx >= 4) return;
    old = shadow[idx];
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) shadow[idx][b*8 +: 8] = data[b*8 +: 8];
    end
    if (idx == reg_ctrl && !old[0] && shadow[idx][0]) jobs++;
  endfunction

  task automatic end_test(string name);
    if (fail_count == test_fails) begin
      $display("%s: ok", name);
    end else begin
      $display("%s: %0d errors", name, fail_count - test_fails);
    end
    test_fails = fail_count;
  endtask

  task automatic finish_run();
    $display("checks passed %0d, failed %0d", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  endtask

  task automatic stop_on_timeout(string what);
    fail_count++;
    $display("timeout while waiting for %s at %0t", what, $time);
    finish_run();
  endtask

  `include "ninjin_top_tb_tasks.svh"

  task automatic run_job(port_word_t w, port_word_t x, port_word_t bias, logic relu);
    int l0;
    int l1;
    int total;
    l0 = pair_dot(w, x, 0);
    l1 = pair_dot(w, x, 2);
    total = l0 + l1 + int'(bias);
    if (relu && total < 0) total = 0;
    write_reg(reg_ctrl, {30'd0, relu, 1'b0}, 4'hf);
    write_reg(reg_weight, w, 4'hf);
    write_reg(reg_input, x, 4'hf);
    write_reg(reg_bias, bias, 4'hf);
    write_reg(reg_ctrl, {30'd0, relu, 1'b1}, 4'hf);
    poll_done();
    read_check(reg_lane0, l0);
    read_check(reg_lane1, l1);
    read_check(reg_result, total);
  endtask

  // ==============================
  // test sequence
  // ==============================

  initial begin
    int idx;
    void'($urandom(76));
    clk = 1'b0;
    xrst = 1'b0;
    req = '0;
    // ports come out of reset as zero
    for (int i = 0; i < 4; i++) begin
      shadow[i] = '0;
    end
    ready_delay_max = 2;
    repeat (4) @(posedge clk);
    #1;
    xrst = 1'b1;

    for (int i = 0; i < port_num; i++) read_check(i, 32'd0);
    end_test("reset values");

    // no job yet so the core still shows zero
    write_reg(reg_result, $urandom, 4'hf);
    read_check(reg_result, 32'd0);
    for (int n = 0; n < 16; n++) begin
      write_reg(n % 4, $urandom, 4'($urandom));
      read_check(n % 4, shadow[n % 4]);
    end
    for (int n = 0; n < 6; n++) begin
      idx = $urandom_range(31, 8);
      write_reg(idx, $urandom, 4'hf);
      read_check(idx, 32'd0);
    end
    for (int i = 0; i < 4; i++) read_check(i, shadow[i]);
    end_test("register access");

    for (int n = 0; n < 4; n++) run_job($urandom, $urandom, $urandom, 1'b0);
    end_test("dot product");

    // lane sums stay within 65536 in magnitude
    run_job($urandom, $urandom, -32'sd100000 - $urandom_range(999, 0), 1'b1);
    run_job($urandom, $urandom, 32'sd100000 + $urandom_range(999, 0), 1'b1);
    end_test("relu");

    ready_delay_max = 12;
    run_job($urandom, $urandom, $urandom, 1'b0);
    run_job($urandom, $urandom, -32'sd100000, 1'b1);
    ready_delay_max = 2;
    end_test("back-pressure");

    // start toggles until the count has wrapped
    while (jobs < 259) begin
      write_reg(reg_ctrl, 32'd0, 4'h1);
      write_reg(reg_ctrl, 32'd1, 4'h1);
    end
    poll_done();
    read_check(reg_status, {16'h0000, 8'(jobs % 256), 7'h00, 1'b1});
    write_reg(reg_ctrl, 32'd1, 4'h1);
    repeat (20) @(posedge clk);
    #1;
    read_check(reg_status, {16'h0000, 8'(jobs % 256), 7'h00, 1'b1});
    end_test("job count");

    finish_run();
  end

endmodule

//--- ninjin_top.f
+incdir+.
ninjin_axi_pkg.sv
ninjin_core_pkg.sv
ninjin_s_axi_lite.sv
ninjin_mac_lane.sv
ninjin_combine.sv
ninjin_core.sv
ninjin_top.sv
ninjin_top_tb.sv

//--- Bender.yml
package:
  name: ninjin

sources:
  - ninjin_axi_pkg.sv
  - ninjin_core_pkg.sv
  - ninjin_s_axi_lite.sv
  - ninjin_mac_lane.sv
  - ninjin_combine.sv
  - ninjin_core.sv
  - ninjin_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - ninjin_top_tb.sv
